//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpuCoreTb \
    -f sim.f -o cpuCoreSim
./obj_dir/cpuCoreSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

//--- sim.f
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/decode.sv
verilog/hazardUnit.sv
verilog/idExReg.sv
verilog/execute.sv
verilog/memWb.sv
verilog/cpuCore.sv
tb/cpuCoreTb.sv

//--- tb/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

    localparam int PROG_LEN    = 40;
    localparam int NUM_RANDOM  = 6;
    localparam int CLEAR_LEN   = 33;  // 32 stores and a halt.
    localparam int TOTAL_INSTR = CLEAR_LEN + NUM_RANDOM * PROG_LEN;
    localparam int CYCLE_LIMIT = 10 * TOTAL_INSTR + 100;
    localparam int BASE_REG    = 7;   // never written, so it stays zero.

    logic                       clk = 1'b0;
    logic                       rst;
    logic [cpuPkg::DATA_W-1:0]  fetchPc;
    logic [cpuPkg::INSTR_W-1:0] instr;
    logic                       wbValid;
    cpuPkg::wbT                 wbOut;
    logic                       halted;
    logic                       err;

    logic [15:0]               prog [64];
    int                        progLen = 0;
    logic [cpuPkg::DATA_W-1:0] refMem [cpuPkg::DMEM_DEPTH];
    cpuPkg::wbT                expectQ [$];
    logic                      expErr;
    logic [31:0]               lfsrState;
    int                        cycleCount = 0;

    always #5 clk = ~clk;

    cpuCore u_cpuCore (.clk(clk), .rst(rst), .fetchPc(fetchPc), .instr(instr),
        .wbValid(wbValid), .wbOut(wbOut), .halted(halted), .err(err));

    // words past the program are addi that must never retire.
    function automatic logic [15:0] fillWord(input logic [15:0] addr);
        return {cpuPkg::OP_ADDI, addr[2:0], addr[5:3], addr[10:6] ^ addr[15:11]};
    endfunction

    assign instr = (int'(fetchPc) < progLen) ? prog[fetchPc[5:0]] : fillWord(fetchPc);

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1.
    endfunction

    function automatic int takeBits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            v = (v << 1) | int'(lfsrState[0]);
        end
        return v;
    endfunction

    function automatic logic [15:0] rType(input int rs, input int rt, input int rd,
                                          input int funct);
        return {cpuPkg::OP_ALU, 3'(rs), 3'(rt), 3'(rd), 2'(funct)};
    endfunction

    function automatic logic [15:0] iType(input cpuPkg::opT op, input int rs, input int rt,
                                          input int imm);
        return {op, 3'(rs), 3'(rt), 5'(imm)};
    endfunction

    function automatic logic [15:0] branchWord(input cpuPkg::opT op, input int rs, input int ofs);
        return {op, 3'(rs), 8'(ofs)};
    endfunction

    function automatic logic [15:0] jumpWord(input int ofs);
        return {cpuPkg::OP_J, 11'(ofs)};
    endfunction

    // zero every word that loads and stores can reach from the base register.
    task automatic buildClear();
        for (int a = 0; a < 32; a++) begin
            prog[6'(a)] = iType(cpuPkg::OP_ST, BASE_REG, 0, a);
        end
        prog[6'(CLEAR_LEN - 1)] = iType(cpuPkg::OP_HALT, 0, 0, 0);
        progLen = CLEAR_LEN;
    endtask

    task automatic buildRandom(input bit withIllegal);
        int illegalPos;
        int limitIdx;
        int i;
        int kind;
        int r;
        int imm;
        illegalPos = withIllegal ? 12 + takeBits(4) : PROG_LEN - 1;
        i = 0;
        while (i < PROG_LEN - 1) begin
            limitIdx = (i < illegalPos) ? illegalPos : PROG_LEN - 1;  // no jump skips it.
            kind = takeBits(4) % 9;
            r = takeBits(3) % 7;
            if (i == illegalPos) begin
                prog[6'(i)] = {5'(9 + takeBits(5) % 23), 11'(takeBits(11))};
            end else begin
                case (kind)
                    0: prog[6'(i)] = '0;
                    1, 2: prog[6'(i)] = rType(takeBits(3), takeBits(3), r, takeBits(2));
                    3: prog[6'(i)] = iType(cpuPkg::OP_ADDI, takeBits(3), r, takeBits(5));
                    4: prog[6'(i)] = iType(cpuPkg::OP_LD, BASE_REG, r, takeBits(5));
                    5: begin
                        imm = takeBits(5);
                        prog[6'(i)] = iType(cpuPkg::OP_ST, BASE_REG, takeBits(3), imm);
                        if (i + 2 < limitIdx) begin
                            // reload the stored word and use it right away.
                            prog[6'(i + 1)] = iType(cpuPkg::OP_LD, BASE_REG, r, imm);
                            prog[6'(i + 2)] = rType(r, takeBits(3), takeBits(3) % 7, 0);
                            i = i + 2;
                        end
                    end
                    6, 7: prog[6'(i)] = branchWord((kind == 6) ? cpuPkg::OP_BEQZ : cpuPkg::OP_BNEZ,
                                                   takeBits(3), takeBits(8) % (limitIdx - i));
                    default: prog[6'(i)] = jumpWord(takeBits(11) % (limitIdx - i));
                endcase
            end
            i = i + 1;
        end
        prog[6'(PROG_LEN - 1)] = iType(cpuPkg::OP_HALT, 0, 0, 0);
        progLen = PROG_LEN;
    endtask

    // architectural run of the program in prog, data memory carries over.
    function automatic void computeReference();
        logic [15:0] regs [8];
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] imm;
        logic [7:0]  addr;
        int          pc;
        int          steps;
        bit          done;
        expectQ.delete();
        expErr = 1'b0;
        for (int k = 0; k < 8; k++) begin
            regs[3'(k)] = '0;
        end
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4 * PROG_LEN) begin
            w = prog[6'(pc)];
            a = regs[w[10:8]];
            b = regs[w[7:5]];
            imm = {{11{w[4]}}, w[4:0]};
            addr = 8'(a + imm);
            pc = pc + 1;
            steps = steps + 1;
            case (w[15:11])
                cpuPkg::OP_NOP: ;
                cpuPkg::OP_HALT: done = 1'b1;
                cpuPkg::OP_ALU: begin
                    case (w[1:0])
                        cpuPkg::ALU_ADD: res = a + b;
                        cpuPkg::ALU_SUB: res = a - b;
                        cpuPkg::ALU_AND: res = a & b;
                        default:         res = a ^ b;
                    endcase
                    regs[w[4:2]] = res;
                    expectQ.push_back('{regAddr: w[4:2], data: res});
                end
                cpuPkg::OP_ADDI: begin
                    regs[w[7:5]] = a + imm;
                    expectQ.push_back('{regAddr: w[7:5], data: a + imm});
                end
                cpuPkg::OP_LD: begin
                    regs[w[7:5]] = refMem[addr];
                    expectQ.push_back('{regAddr: w[7:5], data: refMem[addr]});
                end
                cpuPkg::OP_ST: refMem[addr] = b;
                cpuPkg::OP_BEQZ: if (a == '0) pc = pc + int'($signed(w[7:0]));
                cpuPkg::OP_BNEZ: if (a != '0) pc = pc + int'($signed(w[7:0]));
                cpuPkg::OP_J: pc = pc + int'($signed(w[10:0]));
                default: begin
                    expErr = 1'b1;
                    done = 1'b1;
                end
            endcase
        end
    endfunction

    task automatic stopWithFailure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic checkWb(input cpuPkg::wbT got, input cpuPkg::wbT exp);
        if (got !== exp) begin
            $display("error at %0t: wbOut is r%0d = 0x%h, expected r%0d = 0x%h",
                     $time, got.regAddr, got.data, exp.regAddr, exp.data);
            stopWithFailure();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkPc(input logic [cpuPkg::DATA_W-1:0] got,
                           input logic [cpuPkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: fetchPc is 0x%h, expected 0x%h", $time, got, exp);
            stopWithFailure();
        end
    endtask

    // every retired write must be the next one the reference made.
    always @(negedge clk) begin
        if (!rst && wbValid) begin
            if (expectQ.size() == 0) begin
                $display("write to r%0d at %0t when no write was expected", wbOut.regAddr, $time);
                stopWithFailure();
            end else begin
                checkWb(wbOut, expectQ.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
            stopWithFailure();
        end
    end

    task automatic runProgram(input int index, input bit clearMem, input bit withIllegal);
        logic [cpuPkg::DATA_W-1:0] haltPc;
        @(posedge clk);
        rst <= 1'b1;
        if (clearMem) begin
            buildClear();
        end else begin
            buildRandom(withIllegal);
        end
        computeReference();
        $display("program %0d: %0d writes expected, err %0b", index, expectQ.size(), expErr);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // the first instruction needs four cycles to reach writeback.
        repeat (4) begin
            @(negedge clk);
            checkFlag("wbValid", wbValid, 1'b0);
            checkFlag("halted", halted, 1'b0);
            checkFlag("err", err, 1'b0);
        end
        while (!halted) begin
            @(negedge clk);
        end
        checkFlag("err", err, expErr);
        if (expectQ.size() != 0) begin
            $display("halted at %0t with %0d writes still missing", $time, expectQ.size());
            stopWithFailure();
        end
        haltPc = fetchPc;  // fetch stays frozen once stopped.
        repeat (5) begin
            @(negedge clk);
            checkFlag("halted", halted, 1'b1);
            checkFlag("err", err, expErr);
            checkPc(fetchPc, haltPc);
        end
    endtask

    initial begin
        rst <= 1'b1;
        expErr = 1'b0;
        lfsrState = 32'h0748_311a;
        for (int a = 0; a < 64; a++) begin
            prog[6'(a)] = '0;
        end
        for (int a = 0; a < cpuPkg::DMEM_DEPTH; a++) begin
            refMem[8'(a)] = '0;
        end
        runProgram(0, 1'b1, 1'b0);
        for (int p = 1; p <= NUM_RANDOM; p++) begin
            runProgram(p, 1'b0, p == 4);  // the fourth one stops on an illegal opcode.
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire logic                       clk,
    input  wire logic                       rst,
    output logic      [cpuPkg::DATA_W-1:0]  fetchPc,
    input  wire logic [cpuPkg::INSTR_W-1:0] instr,
    output logic                            wbValid,
    output cpuPkg::wbT                      wbOut,
    output logic                            halted,
    output logic                            err
);

    logic [cpuPkg::DATA_W-1:0]  pc;
    logic [cpuPkg::INSTR_W-1:0] ifInstr;
    logic [cpuPkg::DATA_W-1:0]  ifPc;
    logic [cpuPkg::REG_AW-1:0]  rdAddr1;
    logic [cpuPkg::REG_AW-1:0]  rdAddr2;
    logic [cpuPkg::DATA_W-1:0]  rdData1;
    logic [cpuPkg::DATA_W-1:0]  rdData2;
    cpuPkg::idExT               decPkt;
    cpuPkg::idExT               idExPkt;
    cpuPkg::exMemT              exMemPkt;
    logic                       loadStall;
    logic                       redirect;
    logic [cpuPkg::DATA_W-1:0]  redirectPc;

    assign fetchPc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!halted) begin
            if (redirect) begin
                pc <= redirectPc;
            end else if (!loadStall) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // fetch-to-decode register, a redirect squashes the slot.
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            ifInstr <= {cpuPkg::OP_NOP, {(cpuPkg::INSTR_W - 5){1'b0}}};
        end else if (!loadStall) begin
            ifInstr <= instr;
            ifPc    <= pc;
        end
    end

    regFile u_regFile (.clk(clk), .rst(rst), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
        .rdData1(rdData1), .rdData2(rdData2), .wrEn(wbValid), .wr(wbOut));

    decode u_decode (.instr(ifInstr), .pc(ifPc), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
        .rdData1(rdData1), .rdData2(rdData2), .pkt(decPkt));

    hazardUnit u_hazardUnit (.dec(decPkt), .idEx(idExPkt), .loadStall(loadStall));

    idExReg u_idExReg (.clk(clk), .rst(rst), .pktIn(decPkt), .stallZero(loadStall),
        .flushZero(redirect), .pktOut(idExPkt));

    execute u_execute (.clk(clk), .rst(rst), .idEx(idExPkt), .wbFwdValid(wbValid),
        .wbFwd(wbOut), .redirect(redirect), .redirectPc(redirectPc), .exMem(exMemPkt));

    memWb u_memWb (.clk(clk), .rst(rst), .exMem(exMemPkt), .wbValid(wbValid),
        .wbOut(wbOut), .halted(halted), .err(err));

    assert property (@(posedge clk) disable iff (rst) halted |=> $stable(fetchPc))
        else $error("cpuCore: fetch moved after halt");

endmodule

`default_nettype wire

//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int DATA_W     = 16;
    localparam int INSTR_W    = 16;
    localparam int REG_AW     = 3;
    localparam int DMEM_DEPTH = 256;
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    // instruction field positions, opcode always on top.
    localparam int FIELD_OP_HI    = 15;
    localparam int FIELD_OP_LO    = 11;
    localparam int FIELD_RS_HI    = 10;
    localparam int FIELD_RS_LO    = 8;
    localparam int FIELD_RT_HI    = 7;  // also rd of I-type.
    localparam int FIELD_RT_LO    = 5;
    localparam int FIELD_RD_HI    = 4;
    localparam int FIELD_RD_LO    = 2;
    localparam int FIELD_FUNCT_HI = 1;
    localparam int FIELD_FUNCT_LO = 0;
    localparam int FIELD_IMM_HI   = 4;
    localparam int FIELD_IMM_LO   = 0;
    localparam int FIELD_BOFS_HI  = 7;
    localparam int FIELD_BOFS_LO  = 0;
    localparam int FIELD_JOFS_HI  = 10;
    localparam int FIELD_JOFS_LO  = 0;

    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,
        OP_HALT = 5'd1,
        OP_ALU  = 5'd2,
        OP_ADDI = 5'd3,
        OP_LD   = 5'd4,
        OP_ST   = 5'd5,
        OP_BEQZ = 5'd6,
        OP_BNEZ = 5'd7,
        OP_J    = 5'd8
    } opT;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } aluOpT;

    typedef struct packed {
        aluOpT aluOp;
        logic  aluSrc;    // immediate as second operand.
        logic  branch;
        logic  branchNe;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  regWrite;
        logic  jump;
        logic  halt;
        logic  err;
    } ctrlT;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] readData1;
        logic [DATA_W-1:0] readData2;
        logic [DATA_W-1:0] immVal;
        logic [DATA_W-1:0] jumpDist;
        logic [REG_AW-1:0] writeReg;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic              rsValid;
        logic              rtValid;
        logic              writeRegValid;
        ctrlT              ctrl;
    } idExT;

    typedef struct packed {
        logic [DATA_W-1:0] aluResult;
        logic [DATA_W-1:0] storeData;
        logic [REG_AW-1:0] writeReg;
        logic              regWrite;
        logic              memRead;
        logic              memWrite;
        logic              memToReg;
        logic              halt;
        logic              err;
    } exMemT;

    typedef struct packed {
        logic [REG_AW-1:0] regAddr;
        logic [DATA_W-1:0] data;
    } wbT;

endpackage

`default_nettype wire

//--- verilog/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire logic [cpuPkg::INSTR_W-1:0] instr,
    input  wire logic [cpuPkg::DATA_W-1:0]  pc,
    output logic      [cpuPkg::REG_AW-1:0]  rdAddr1,
    output logic      [cpuPkg::REG_AW-1:0]  rdAddr2,
    input  wire logic [cpuPkg::DATA_W-1:0]  rdData1,
    input  wire logic [cpuPkg::DATA_W-1:0]  rdData2,
    output cpuPkg::idExT                    pkt
);

    cpuPkg::opT                op;
    logic [cpuPkg::REG_AW-1:0] rs;
    logic [cpuPkg::REG_AW-1:0] rt;
    logic [cpuPkg::REG_AW-1:0] rd;
    logic [cpuPkg::DATA_W-1:0] immExt;
    logic [cpuPkg::DATA_W-1:0] brOfs;
    logic [cpuPkg::DATA_W-1:0] jOfs;

    assign op = cpuPkg::opT'(instr[cpuPkg::FIELD_OP_HI:cpuPkg::FIELD_OP_LO]);
    assign rs = instr[cpuPkg::FIELD_RS_HI:cpuPkg::FIELD_RS_LO];
    assign rt = instr[cpuPkg::FIELD_RT_HI:cpuPkg::FIELD_RT_LO];
    assign rd = instr[cpuPkg::FIELD_RD_HI:cpuPkg::FIELD_RD_LO];

    // sign extension, all offset fields start at bit 0.
    assign immExt = {{(cpuPkg::DATA_W - cpuPkg::FIELD_IMM_HI - 1){instr[cpuPkg::FIELD_IMM_HI]}},
                     instr[cpuPkg::FIELD_IMM_HI:cpuPkg::FIELD_IMM_LO]};
    assign brOfs = {{(cpuPkg::DATA_W - cpuPkg::FIELD_BOFS_HI - 1){instr[cpuPkg::FIELD_BOFS_HI]}},
                    instr[cpuPkg::FIELD_BOFS_HI:cpuPkg::FIELD_BOFS_LO]};
    assign jOfs = {{(cpuPkg::DATA_W - cpuPkg::FIELD_JOFS_HI - 1){instr[cpuPkg::FIELD_JOFS_HI]}},
                   instr[cpuPkg::FIELD_JOFS_HI:cpuPkg::FIELD_JOFS_LO]};

    assign rdAddr1 = rs;
    assign rdAddr2 = rt;

    always_comb begin
        pkt           = '0;
        pkt.pc        = pc;
        pkt.readData1 = rdData1;
        pkt.readData2 = rdData2;
        pkt.immVal    = immExt;
        pkt.jumpDist  = (op == cpuPkg::OP_J) ? jOfs : brOfs;
        pkt.rs        = rs;
        pkt.rt        = rt;
        pkt.writeReg  = rt;
        pkt.ctrl.aluOp = cpuPkg::ALU_ADD;
        case (op)
            cpuPkg::OP_NOP: ;
            cpuPkg::OP_HALT: pkt.ctrl.halt = 1'b1;
            cpuPkg::OP_ALU: begin
                pkt.ctrl.aluOp    = cpuPkg::aluOpT'(instr[cpuPkg::FIELD_FUNCT_HI:
                                                          cpuPkg::FIELD_FUNCT_LO]);
                pkt.ctrl.regWrite = 1'b1;
                pkt.rsValid       = 1'b1;
                pkt.rtValid       = 1'b1;
                pkt.writeReg      = rd;
            end
            cpuPkg::OP_ADDI: begin
                pkt.ctrl.aluSrc   = 1'b1;
                pkt.ctrl.regWrite = 1'b1;
                pkt.rsValid       = 1'b1;
            end
            cpuPkg::OP_LD: begin
                pkt.ctrl.aluSrc   = 1'b1;
                pkt.ctrl.memRead  = 1'b1;
                pkt.ctrl.memToReg = 1'b1;
                pkt.ctrl.regWrite = 1'b1;
                pkt.rsValid       = 1'b1;
            end
            cpuPkg::OP_ST: begin
                pkt.ctrl.aluSrc   = 1'b1;
                pkt.ctrl.memWrite = 1'b1;
                pkt.rsValid       = 1'b1;
                pkt.rtValid       = 1'b1;  // store data.
            end
            cpuPkg::OP_BEQZ, cpuPkg::OP_BNEZ: begin
                pkt.ctrl.branch   = 1'b1;
                pkt.ctrl.branchNe = (op == cpuPkg::OP_BNEZ);
                pkt.rsValid       = 1'b1;
            end
            cpuPkg::OP_J: pkt.ctrl.jump = 1'b1;
            default: begin
                // illegal opcode stops the machine.
                pkt.ctrl.err  = 1'b1;
                pkt.ctrl.halt = 1'b1;
            end
        endcase
        pkt.writeRegValid = pkt.ctrl.regWrite;
    end

    always_comb begin
        assert (!(op == cpuPkg::OP_J && pkt.rsValid))
            else $error("decode: jump marks rs as a source");
    end

endmodule

`default_nettype wire

//--- verilog/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire cpuPkg::idExT              idEx,
    input  wire logic                      wbFwdValid,
    input  wire cpuPkg::wbT                wbFwd,
    output logic                           redirect,
    output logic      [cpuPkg::DATA_W-1:0] redirectPc,
    output cpuPkg::exMemT                  exMem
);

    cpuPkg::exMemT             exMemQ;
    cpuPkg::exMemT             exMemD;
    logic [cpuPkg::DATA_W-1:0] rsVal;
    logic [cpuPkg::DATA_W-1:0] rtVal;
    logic [cpuPkg::DATA_W-1:0] aluB;
    logic [cpuPkg::DATA_W-1:0] aluOut;
    logic [cpuPkg::DATA_W-1:0] pcNext;
    logic                      rsZero;

    // the EX/MEM result is newer than the writeback one.
    always_comb begin
        rsVal = idEx.readData1;
        rtVal = idEx.readData2;
        if (exMemQ.regWrite && exMemQ.writeReg == idEx.rs) begin
            rsVal = exMemQ.aluResult;
        end else if (wbFwdValid && wbFwd.regAddr == idEx.rs) begin
            rsVal = wbFwd.data;
        end
        if (exMemQ.regWrite && exMemQ.writeReg == idEx.rt) begin
            rtVal = exMemQ.aluResult;
        end else if (wbFwdValid && wbFwd.regAddr == idEx.rt) begin
            rtVal = wbFwd.data;
        end
    end

    assign aluB = idEx.ctrl.aluSrc ? idEx.immVal : rtVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            cpuPkg::ALU_ADD: aluOut = rsVal + aluB;
            cpuPkg::ALU_SUB: aluOut = rsVal - aluB;
            cpuPkg::ALU_AND: aluOut = rsVal & aluB;
            cpuPkg::ALU_XOR: aluOut = rsVal ^ aluB;
            default:         aluOut = '0;
        endcase
    end

    // branches and jumps share the pc+1 relative target.
    assign rsZero     = (rsVal == '0);
    assign pcNext     = idEx.pc + 1'b1;
    assign redirectPc = pcNext + idEx.jumpDist;
    assign redirect   = idEx.ctrl.jump || (idEx.ctrl.branch && (rsZero ^ idEx.ctrl.branchNe));

    always_comb begin
        exMemD.aluResult = aluOut;
        exMemD.storeData = rtVal;
        exMemD.writeReg  = idEx.writeReg;
        exMemD.regWrite  = idEx.ctrl.regWrite;
        exMemD.memRead   = idEx.ctrl.memRead;
        exMemD.memWrite  = idEx.ctrl.memWrite;
        exMemD.memToReg  = idEx.ctrl.memToReg;
        exMemD.halt      = idEx.ctrl.halt;
        exMemD.err       = idEx.ctrl.err;
    end

    always_ff @(posedge clk) begin
        exMemQ <= exMemD;
        if (rst) begin
            exMemQ.regWrite <= 1'b0;
            exMemQ.memRead  <= 1'b0;
            exMemQ.memWrite <= 1'b0;
            exMemQ.memToReg <= 1'b0;
            exMemQ.halt     <= 1'b0;
            exMemQ.err      <= 1'b0;
        end
    end

    assign exMem = exMemQ;

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire cpuPkg::idExT dec,
    input  wire cpuPkg::idExT idEx,
    output logic              loadStall
);

    logic loadInEx;
    logic rsHit;
    logic rtHit;

    // only a load leaves its result too late for forwarding.
    assign loadInEx = idEx.ctrl.memRead && idEx.writeRegValid;

    assign rsHit = dec.rsValid && (dec.rs == idEx.writeReg);
    assign rtHit = dec.rtValid && (dec.rt == idEx.writeReg);

    assign loadStall = loadInEx && (rsHit || rtHit);  // one bubble is enough.

endmodule

`default_nettype wire

//--- verilog/idExReg.sv
`timescale 1ns/1ps
`default_nettype none

module idExReg (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire cpuPkg::idExT pktIn,
    input  wire logic         stallZero,
    input  wire logic         flushZero,
    output cpuPkg::idExT      pktOut
);

    logic         controlZero;
    cpuPkg::idExT pktNext;

    assign controlZero = stallZero | flushZero;

    // a zeroed slot travels on as a bubble with no side effects.
    always_comb begin
        pktNext = pktIn;
        if (controlZero) begin
            pktNext.ctrl.branch   = 1'b0;
            pktNext.ctrl.jump     = 1'b0;
            pktNext.ctrl.memRead  = 1'b0;
            pktNext.ctrl.memWrite = 1'b0;
            pktNext.ctrl.regWrite = 1'b0;
            pktNext.ctrl.halt     = 1'b0;
            pktNext.ctrl.err      = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        pktOut <= pktNext;
        if (rst) begin
            pktOut.ctrl          <= '0;
            pktOut.rsValid       <= 1'b0;
            pktOut.rtValid       <= 1'b0;
            pktOut.writeRegValid <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        controlZero |=> !pktOut.ctrl.memWrite && !pktOut.ctrl.regWrite)
        else $error("idExReg: bubble carries a write");

endmodule

`default_nettype wire

//--- verilog/memWb.sv
`timescale 1ns/1ps
`default_nettype none

module memWb (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire cpuPkg::exMemT exMem,
    output logic               wbValid,
    output cpuPkg::wbT         wbOut,
    output logic               halted,
    output logic               err
);

    logic [cpuPkg::DATA_W-1:0]  dmem [cpuPkg::DMEM_DEPTH];
    logic [cpuPkg::DMEM_AW-1:0] addr;
    logic [cpuPkg::DATA_W-1:0]  loadData;

    assign addr     = exMem.aluResult[cpuPkg::DMEM_AW-1:0];  // word address.
    assign loadData = dmem[addr];

    // stores behind a halt never land.
    always_ff @(posedge clk) begin
        if (exMem.memWrite && !halted) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk) begin
        wbOut.regAddr <= exMem.writeReg;
        wbOut.data    <= exMem.memToReg ? loadData : exMem.aluResult;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
            halted  <= 1'b0;
            err     <= 1'b0;
        end else if (!halted) begin
            wbValid <= exMem.regWrite;
            halted  <= exMem.halt;
            err     <= exMem.err;
        end else begin
            wbValid <= 1'b0;  // nothing retires once stopped.
        end
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [cpuPkg::REG_AW-1:0] rdAddr1,
    input  wire logic [cpuPkg::REG_AW-1:0] rdAddr2,
    output logic      [cpuPkg::DATA_W-1:0] rdData1,
    output logic      [cpuPkg::DATA_W-1:0] rdData2,
    input  wire logic                      wrEn,
    input  wire cpuPkg::wbT                wr
);

    logic [cpuPkg::DATA_W-1:0] regs [2**cpuPkg::REG_AW];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**cpuPkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wr.regAddr] <= wr.data;
        end
    end

    // a write in flight is visible to decode in the same cycle.
    always_comb begin
        rdData1 = regs[rdAddr1];
        rdData2 = regs[rdAddr2];
        if (wrEn && wr.regAddr == rdAddr1) begin
            rdData1 = wr.data;
        end
        if (wrEn && wr.regAddr == rdAddr2) begin
            rdData2 = wr.data;
        end
    end

endmodule

`default_nettype wire
